//--- logic/control_pkg.sv
`default_nettype none

package control_pkg;

    localparam int OPCODE_W = 6;
    localparam int FUNCT_W = 6;
    localparam int STEP_W = 3;
    localparam int CLS_W = 4;

    localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'b000000;
    localparam logic [OPCODE_W-1:0] OP_LW = 6'b100011;
    localparam logic [OPCODE_W-1:0] OP_SW = 6'b101011;
    localparam logic [OPCODE_W-1:0] OP_ADDI = 6'b001000;
    localparam logic [OPCODE_W-1:0] OP_ANDI = 6'b001100;
    localparam logic [OPCODE_W-1:0] OP_ORI = 6'b001101;
    localparam logic [OPCODE_W-1:0] OP_SLTI = 6'b001010;
    localparam logic [OPCODE_W-1:0] OP_BEQ = 6'b000100;
    localparam logic [OPCODE_W-1:0] OP_BNE = 6'b000101;
    localparam logic [OPCODE_W-1:0] OP_J = 6'b000010;
    localparam logic [OPCODE_W-1:0] OP_JAL = 6'b000011;

    localparam logic [FUNCT_W-1:0] FN_ADD = 6'b100000;
    localparam logic [FUNCT_W-1:0] FN_SUB = 6'b100010;
    localparam logic [FUNCT_W-1:0] FN_AND = 6'b100100;
    localparam logic [FUNCT_W-1:0] FN_OR = 6'b100101;
    localparam logic [FUNCT_W-1:0] FN_SLT = 6'b101010;
    localparam logic [FUNCT_W-1:0] FN_JR = 6'b001000;

    // One class per kept instruction, so the ALU op survives the decode step
    localparam logic [CLS_W-1:0] CLS_ADD = 4'd0;
    localparam logic [CLS_W-1:0] CLS_SUB = 4'd1;
    localparam logic [CLS_W-1:0] CLS_AND = 4'd2;
    localparam logic [CLS_W-1:0] CLS_OR = 4'd3;
    localparam logic [CLS_W-1:0] CLS_SLT = 4'd4;
    localparam logic [CLS_W-1:0] CLS_ADDI = 4'd5;
    localparam logic [CLS_W-1:0] CLS_ANDI = 4'd6;
    localparam logic [CLS_W-1:0] CLS_ORI = 4'd7;
    localparam logic [CLS_W-1:0] CLS_SLTI = 4'd8;
    localparam logic [CLS_W-1:0] CLS_LW = 4'd9;
    localparam logic [CLS_W-1:0] CLS_SW = 4'd10;
    localparam logic [CLS_W-1:0] CLS_BEQ = 4'd11;
    localparam logic [CLS_W-1:0] CLS_BNE = 4'd12;
    localparam logic [CLS_W-1:0] CLS_J = 4'd13;
    localparam logic [CLS_W-1:0] CLS_JAL = 4'd14;
    localparam logic [CLS_W-1:0] CLS_JR = 4'd15;

    localparam logic [STEP_W-1:0] FETCH_STEPS = 3'd2;
    localparam logic [STEP_W-1:0] DECODE_STEPS = 3'd1;
    localparam logic [STEP_W-1:0] EXEC_STEPS_ALU = 3'd2;
    localparam logic [STEP_W-1:0] EXEC_STEPS_LW = 3'd4;
    localparam logic [STEP_W-1:0] EXEC_STEPS_SW = 3'd2;
    localparam logic [STEP_W-1:0] EXEC_STEPS_BRANCH = 3'd2;
    localparam logic [STEP_W-1:0] EXEC_STEPS_JUMP = 3'd1;
    localparam logic [STEP_W-1:0] EXEC_STEPS_JAL = 3'd2;
    // Write-back step of ALU classes, where overflow is checked
    localparam logic [STEP_W-1:0] ALU_OVF_STEP = 3'd1;

    localparam logic [1:0] PH_FETCH = 2'd0;
    localparam logic [1:0] PH_DECODE = 2'd1;
    localparam logic [1:0] PH_EXEC = 2'd2;
    localparam logic [1:0] PH_EXC = 2'd3;

    localparam logic [2:0] ALU_OP_ADD = 3'b001;
    localparam logic [2:0] ALU_OP_SUB = 3'b010;
    localparam logic [2:0] ALU_OP_AND = 3'b011;
    localparam logic [2:0] ALU_OP_OR = 3'b100;
    localparam logic [2:0] ALU_OP_SLT = 3'b101;

    localparam logic [1:0] SRC_A_PC = 2'b00;
    localparam logic [1:0] SRC_A_REG_A = 2'b10;
    localparam logic [2:0] SRC_B_REG_B = 3'b000;
    localparam logic [2:0] SRC_B_FOUR = 3'b001;
    localparam logic [2:0] SRC_B_IMM = 3'b010;
    localparam logic [2:0] SRC_B_BRANCH_OFS = 3'b011;

    localparam logic [1:0] DST_RT = 2'b00;
    localparam logic [1:0] DST_RD = 2'b01;
    localparam logic [1:0] DST_RA = 2'b10;
    localparam logic [2:0] WB_MDR = 3'b010;
    localparam logic [2:0] WB_ALU_OUT = 3'b011;
    localparam logic [2:0] WB_PC = 3'b110;
    localparam logic [2:0] ADDR_PC = 3'b000;
    localparam logic [2:0] ADDR_ALU_OUT = 3'b100;

    localparam logic [2:0] PC_SRC_ALU = 3'b000;
    localparam logic [2:0] PC_SRC_ALU_OUT = 3'b001;
    localparam logic [2:0] PC_SRC_REG_A = 3'b010;
    localparam logic [2:0] PC_SRC_JUMP = 3'b011;
    localparam logic [2:0] PC_SRC_EXC = 3'b100;

    localparam logic [1:0] CAUSE_OVERFLOW = 2'b00;
    localparam logic [1:0] CAUSE_ILLEGAL = 2'b10;

    typedef struct packed {
        logic illegal;
        logic [CLS_W-1:0] cls;
    } decode_t;

    typedef struct packed {
        logic [1:0] phase;
        logic [STEP_W-1:0] step;
        logic active;
        logic [CLS_W-1:0] cls_held;
    } phase_t;

    typedef struct packed {
        logic [2:0] mem_addr_sel;
        logic mem_wr;
        logic ir_wr;
        logic reg_wr;
        logic ab_wr;
        logic [1:0] reg_dst;
        logic [2:0] wb_sel;
        logic [1:0] alu_src_a;
        logic [2:0] alu_src_b;
        logic [2:0] alu_op;
        logic alu_out_wr;
        logic [2:0] pc_src;
        logic pc_wr;
        logic epc_wr;
        logic [1:0] cause;
    } ctrl_word_t;

    function automatic logic [STEP_W-1:0] exec_steps(input logic [CLS_W-1:0] cls);
        case (cls)
            CLS_LW: return EXEC_STEPS_LW;
            CLS_SW: return EXEC_STEPS_SW;
            CLS_BEQ, CLS_BNE: return EXEC_STEPS_BRANCH;
            CLS_J, CLS_JR: return EXEC_STEPS_JUMP;
            CLS_JAL: return EXEC_STEPS_JAL;
            default: return EXEC_STEPS_ALU;
        endcase
    endfunction

    // Only these can raise the overflow exception
    function automatic logic is_add_type(input logic [CLS_W-1:0] cls);
        return cls inside {CLS_ADD, CLS_SUB, CLS_ADDI};
    endfunction

endpackage

`default_nettype wire

//--- logic/control_unit.sv
`default_nettype none

module control_unit import control_pkg::*; (
    input wire logic clk,
    input wire logic reset,
    input wire logic [OPCODE_W-1:0] opcode,
    input wire logic [FUNCT_W-1:0] funct,
    input wire logic overflow,
    input wire logic zero,
    output ctrl_word_t ctrl
);

    decode_t dec;
    phase_t ph;

    instr_decoder i_decoder (
        .opcode(opcode),
        .funct(funct),
        .dec(dec)
    );

    step_sequencer i_sequencer (
        .clk(clk),
        .reset(reset),
        .dec(dec),
        .overflow(overflow),
        .ph(ph)
    );

    control_word_gen i_word_gen (
        .ph(ph),
        .zero(zero),
        .overflow(overflow),
        .ctrl(ctrl)
    );

endmodule

`default_nettype wire

//--- logic/control_word_gen.sv
`default_nettype none

module control_word_gen import control_pkg::*; (
    input phase_t ph,
    input wire logic zero,
    input wire logic overflow,
    output ctrl_word_t ctrl
);

    logic alu_cls;
    logic imm_cls;
    logic [2:0] cls_alu_op;

    // ALU operation and operand kind of the held class
    always_comb begin
        alu_cls = 1'b1;
        imm_cls = 1'b0;
        cls_alu_op = ALU_OP_ADD;
        case (ph.cls_held)
            CLS_ADD: cls_alu_op = ALU_OP_ADD;
            CLS_SUB: cls_alu_op = ALU_OP_SUB;
            CLS_AND: cls_alu_op = ALU_OP_AND;
            CLS_OR: cls_alu_op = ALU_OP_OR;
            CLS_SLT: cls_alu_op = ALU_OP_SLT;
            CLS_ADDI: imm_cls = 1'b1;
            CLS_ANDI: begin
                imm_cls = 1'b1;
                cls_alu_op = ALU_OP_AND;
            end
            CLS_ORI: begin
                imm_cls = 1'b1;
                cls_alu_op = ALU_OP_OR;
            end
            CLS_SLTI: begin
                imm_cls = 1'b1;
                cls_alu_op = ALU_OP_SLT;
            end
            default: alu_cls = 1'b0;
        endcase
    end

    always_comb begin
        ctrl = '0;
        if (ph.active) begin
            case (ph.phase)
                PH_FETCH: begin
                    // Memory reads at PC while the ALU forms PC+4
                    ctrl.mem_addr_sel = ADDR_PC;
                    ctrl.alu_src_a = SRC_A_PC;
                    ctrl.alu_src_b = SRC_B_FOUR;
                    ctrl.alu_op = ALU_OP_ADD;
                    if (ph.step == FETCH_STEPS - 1'b1) begin
                        ctrl.ir_wr = 1'b1;
                        ctrl.pc_src = PC_SRC_ALU;
                        ctrl.pc_wr = 1'b1;
                    end
                end
                PH_DECODE: begin
                    // Branch target lands in ALUOut
                    ctrl.ab_wr = 1'b1;
                    ctrl.alu_src_a = SRC_A_PC;
                    ctrl.alu_src_b = SRC_B_BRANCH_OFS;
                    ctrl.alu_op = ALU_OP_ADD;
                    ctrl.alu_out_wr = 1'b1;
                end
                PH_EXEC: begin
                    if (alu_cls) begin
                        if (ph.step == '0) begin
                            ctrl.alu_src_a = SRC_A_REG_A;
                            ctrl.alu_src_b = imm_cls ? SRC_B_IMM : SRC_B_REG_B;
                            ctrl.alu_op = cls_alu_op;
                            ctrl.alu_out_wr = 1'b1;
                        end else if (!(is_add_type(ph.cls_held) && overflow)) begin
                            ctrl.reg_wr = 1'b1;
                            ctrl.reg_dst = imm_cls ? DST_RT : DST_RD;
                            ctrl.wb_sel = WB_ALU_OUT;
                        end
                    end else begin
                        case (ph.cls_held)
                            CLS_LW, CLS_SW: begin
                                if (ph.step == '0) begin
                                    ctrl.alu_src_a = SRC_A_REG_A;
                                    ctrl.alu_src_b = SRC_B_IMM;
                                    ctrl.alu_op = ALU_OP_ADD;
                                    ctrl.alu_out_wr = 1'b1;
                                end else if (ph.cls_held == CLS_SW) begin
                                    ctrl.mem_addr_sel = ADDR_ALU_OUT;
                                    ctrl.mem_wr = 1'b1;
                                end else if (ph.step == EXEC_STEPS_LW - 1'b1) begin
                                    ctrl.reg_wr = 1'b1;
                                    ctrl.reg_dst = DST_RT;
                                    ctrl.wb_sel = WB_MDR;
                                end else begin
                                    ctrl.mem_addr_sel = ADDR_ALU_OUT;
                                end
                            end
                            CLS_BEQ, CLS_BNE: begin
                                // Compare only, ALUOut keeps the target
                                ctrl.alu_src_a = SRC_A_REG_A;
                                ctrl.alu_src_b = SRC_B_REG_B;
                                ctrl.alu_op = ALU_OP_SUB;
                                if (ph.step != '0 && (zero == (ph.cls_held == CLS_BEQ))) begin
                                    ctrl.pc_src = PC_SRC_ALU_OUT;
                                    ctrl.pc_wr = 1'b1;
                                end
                            end
                            CLS_J: begin
                                ctrl.pc_src = PC_SRC_JUMP;
                                ctrl.pc_wr = 1'b1;
                            end
                            CLS_JR: begin
                                ctrl.pc_src = PC_SRC_REG_A;
                                ctrl.pc_wr = 1'b1;
                            end
                            CLS_JAL: begin
                                if (ph.step == '0) begin
                                    ctrl.reg_wr = 1'b1;
                                    ctrl.reg_dst = DST_RA;
                                    ctrl.wb_sel = WB_PC;
                                end else begin
                                    ctrl.pc_src = PC_SRC_JUMP;
                                    ctrl.pc_wr = 1'b1;
                                end
                            end
                            default: begin
                            end
                        endcase
                    end
                end
                default: begin
                    // EPC takes PC-4, the faulting instruction
                    ctrl.alu_src_a = SRC_A_PC;
                    ctrl.alu_src_b = SRC_B_FOUR;
                    ctrl.alu_op = ALU_OP_SUB;
                    ctrl.epc_wr = 1'b1;
                    ctrl.cause = (ph.step == ALU_OVF_STEP) ? CAUSE_OVERFLOW : CAUSE_ILLEGAL;
                    ctrl.pc_src = PC_SRC_EXC;
                    ctrl.pc_wr = 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/instr_decoder.sv
`default_nettype none

module instr_decoder import control_pkg::*; (
    input wire logic [OPCODE_W-1:0] opcode,
    input wire logic [FUNCT_W-1:0] funct,
    output decode_t dec
);

    always_comb begin
        dec.illegal = 1'b0;
        dec.cls = CLS_ADD;
        case (opcode)
            OP_RTYPE: begin
                case (funct)
                    FN_ADD: dec.cls = CLS_ADD;
                    FN_SUB: dec.cls = CLS_SUB;
                    FN_AND: dec.cls = CLS_AND;
                    FN_OR: dec.cls = CLS_OR;
                    FN_SLT: dec.cls = CLS_SLT;
                    FN_JR: dec.cls = CLS_JR;
                    // mult, div, shifts and the rest land here
                    default: dec.illegal = 1'b1;
                endcase
            end
            OP_LW: dec.cls = CLS_LW;
            OP_SW: dec.cls = CLS_SW;
            OP_ADDI: dec.cls = CLS_ADDI;
            OP_ANDI: dec.cls = CLS_ANDI;
            OP_ORI: dec.cls = CLS_ORI;
            OP_SLTI: dec.cls = CLS_SLTI;
            OP_BEQ: dec.cls = CLS_BEQ;
            OP_BNE: dec.cls = CLS_BNE;
            OP_J: dec.cls = CLS_J;
            OP_JAL: dec.cls = CLS_JAL;
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/step_sequencer.sv
`default_nettype none

module step_sequencer import control_pkg::*; (
    input wire logic clk,
    input wire logic reset,
    input decode_t dec,
    input wire logic overflow,
    output phase_t ph
);

    logic exec_last;
    logic ovf_trap;

    assign exec_last = (ph.step == exec_steps(ph.cls_held) - 1'b1);
    assign ovf_trap = is_add_type(ph.cls_held) && (ph.step == ALU_OVF_STEP) && overflow;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ph.phase <= PH_FETCH;
            ph.step <= '0;
            ph.active <= 1'b0;
            ph.cls_held <= CLS_ADD;
        end else if (!ph.active) begin
            // Start cycle, fetch begins on the next one
            ph.active <= 1'b1;
        end else begin
            case (ph.phase)
                PH_FETCH: begin
                    if (ph.step == FETCH_STEPS - 1'b1) begin
                        ph.phase <= PH_DECODE;
                        ph.step <= '0;
                    end else begin
                        ph.step <= ph.step + 1'b1;
                    end
                end
                PH_DECODE: begin
                    if (ph.step == DECODE_STEPS - 1'b1) begin
                        ph.cls_held <= dec.cls;
                        ph.phase <= dec.illegal ? PH_EXC : PH_EXEC;
                        ph.step <= '0;
                    end else begin
                        ph.step <= ph.step + 1'b1;
                    end
                end
                PH_EXEC: begin
                    if (ovf_trap) begin
                        // Step stays at ALU_OVF_STEP, which marks the overflow cause
                        ph.phase <= PH_EXC;
                    end else if (exec_last) begin
                        ph.phase <= PH_FETCH;
                        ph.step <= '0;
                    end else begin
                        ph.step <= ph.step + 1'b1;
                    end
                end
                default: begin
                    ph.phase <= PH_FETCH;
                    ph.step <= '0;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        ph.phase == PH_EXEC |-> ph.step < exec_steps(ph.cls_held))
    else $error("step_sequencer: step %0d past class %0d", ph.step, ph.cls_held);

    assert property (@(posedge clk) disable iff (reset)
        ph.phase == PH_EXC |=> ph.phase == PH_FETCH)
    else $error("step_sequencer: exception phase longer than one cycle");

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps -Mdir obj_dir \
        --top-module control_unit_tb -f sources.f; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vcontrol_unit_tb 2>&1)
sim_status=$?
echo "$sim_output"
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- sources.f
logic/control_pkg.sv
logic/instr_decoder.sv
logic/step_sequencer.sv
logic/control_word_gen.sv
logic/control_unit.sv
tb/control_unit_tb.sv

//--- tb/control_unit_tb.sv
`default_nettype none

module control_unit_tb import control_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // Strobe counts and selects seen between two ir_wr pulses
    typedef struct packed {
        logic [7:0] length;
        logic [3:0] reg_wr_n;
        logic [1:0] reg_dst;
        logic [2:0] wb_sel;
        logic [3:0] jump_n;
        logic [2:0] pc_src;
        logic [3:0] epc_n;
        logic [1:0] cause;
        logic [3:0] mem_wr_n;
    } counts_t;

    typedef struct packed {
        logic [OPCODE_W-1:0] opcode;
        logic [FUNCT_W-1:0] funct;
        logic overflow;
        logic zero;
        counts_t exp;
    } entry_t;

    logic clk;
    logic reset;
    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT_W-1:0] funct;
    logic overflow;
    logic zero;
    ctrl_word_t ctrl;

    entry_t table_q[$];
    string name_q[$];
    counts_t done_q[$];
    counts_t cur;
    logic window_open;

    control_unit i_dut (
        .clk(clk),
        .reset(reset),
        .opcode(opcode),
        .funct(funct),
        .overflow(overflow),
        .zero(zero),
        .ctrl(ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // A window runs from one ir_wr pulse up to the next
    always @(posedge clk) begin
        if (reset) begin
            window_open = 1'b0;
            cur = '0;
        end else begin
            if (ctrl.ir_wr) begin
                if (window_open) begin
                    done_q.push_back(cur);
                end
                window_open = 1'b1;
                cur = '0;
            end
            if (window_open) begin
                cur.length = cur.length + 8'd1;
                if (ctrl.reg_wr) begin
                    cur.reg_wr_n = cur.reg_wr_n + 4'd1;
                    cur.reg_dst = ctrl.reg_dst;
                    cur.wb_sel = ctrl.wb_sel;
                end
                // PC+4 of the fetch step is left out
                if (ctrl.pc_wr && !ctrl.ir_wr) begin
                    cur.jump_n = cur.jump_n + 4'd1;
                    cur.pc_src = ctrl.pc_src;
                end
                if (ctrl.epc_wr) begin
                    cur.epc_n = cur.epc_n + 4'd1;
                    cur.cause = ctrl.cause;
                end
                if (ctrl.mem_wr) begin
                    cur.mem_wr_n = cur.mem_wr_n + 4'd1;
                end
            end
        end
    end

    function automatic logic [6:0] enables(input ctrl_word_t c);
        return {c.mem_wr, c.ir_wr, c.reg_wr, c.ab_wr, c.alu_out_wr, c.pc_wr, c.epc_wr};
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string test, input string what,
                               input int expected, input int actual);
        assert (actual == expected)
        else fail_run($sformatf("Error: %s %s expected %0d actual %0d",
                                test, what, expected, actual));
    endtask

    task automatic add_row(input string name, input logic [OPCODE_W-1:0] op,
                           input logic [FUNCT_W-1:0] fn, input logic ovf, input logic z,
                           input int length, input int reg_wr_n, input logic [1:0] reg_dst,
                           input logic [2:0] wb_sel, input int jump_n,
                           input logic [2:0] pc_src, input int epc_n,
                           input logic [1:0] cause, input int mem_wr_n);
        entry_t row;
        row.opcode = op;
        row.funct = fn;
        row.overflow = ovf;
        row.zero = z;
        row.exp.length = 8'(length);
        row.exp.reg_wr_n = 4'(reg_wr_n);
        row.exp.reg_dst = reg_dst;
        row.exp.wb_sel = wb_sel;
        row.exp.jump_n = 4'(jump_n);
        row.exp.pc_src = pc_src;
        row.exp.epc_n = 4'(epc_n);
        row.exp.cause = cause;
        row.exp.mem_wr_n = 4'(mem_wr_n);
        table_q.push_back(row);
        name_q.push_back(name);
    endtask

    // Length is fetch 2 + decode 1 + execute steps of the class
    task automatic build_table();
        add_row("add", OP_RTYPE, FN_ADD, 1'b0, 1'b0,
                5, 1, DST_RD, WB_ALU_OUT, 0, PC_SRC_ALU, 0, CAUSE_OVERFLOW, 0);
        add_row("sub", OP_RTYPE, FN_SUB, 1'b0, 1'b0,
                5, 1, DST_RD, WB_ALU_OUT, 0, PC_SRC_ALU, 0, CAUSE_OVERFLOW, 0);
        add_row("and", OP_RTYPE, FN_AND, 1'b0, 1'b0,
                5, 1, DST_RD, WB_ALU_OUT, 0, PC_SRC_ALU, 0, CAUSE_OVERFLOW, 0);
        add_row("or", OP_RTYPE, FN_OR, 1'b0, 1'b0,
                5, 1, DST_RD, WB_ALU_OUT, 0, PC_SRC_ALU, 0, CAUSE_OVERFLOW, 0);
        add_row("slt", OP_RTYPE, FN_SLT, 1'b0, 1'b0,
                5, 1, DST_RD, WB_ALU_OUT, 0, PC_SRC_ALU, 0, CAUSE_OVERFLOW, 0);
        add_row("addi", OP_ADDI, 6'h00, 1'b0, 1'b0,
                5, 1, DST_RT, WB_ALU_OUT, 0, PC_SRC_ALU, 0, CAUSE_OVERFLOW, 0);
        add_row("andi", OP_ANDI, 6'h00, 1'b0, 1'b0,
                5, 1, DST_RT, WB_ALU_OUT, 0, PC_SRC_ALU, 0, CAUSE_OVERFLOW, 0);
        add_row("ori", OP_ORI, 6'h00, 1'b0, 1'b0,
                5, 1, DST_RT, WB_ALU_OUT, 0, PC_SRC_ALU, 0, CAUSE_OVERFLOW, 0);
        add_row("slti", OP_SLTI, 6'h00, 1'b0, 1'b0,
                5, 1, DST_RT, WB_ALU_OUT, 0, PC_SRC_ALU, 0, CAUSE_OVERFLOW, 0);
        add_row("lw", OP_LW, 6'h00, 1'b0, 1'b0,
                7, 1, DST_RT, WB_MDR, 0, PC_SRC_ALU, 0, CAUSE_OVERFLOW, 0);
        add_row("sw", OP_SW, 6'h00, 1'b0, 1'b0,
                5, 0, DST_RT, WB_ALU_OUT, 0, PC_SRC_ALU, 0, CAUSE_OVERFLOW, 1);
        add_row("beq taken", OP_BEQ, 6'h00, 1'b0, 1'b1,
                5, 0, DST_RT, WB_ALU_OUT, 1, PC_SRC_ALU_OUT, 0, CAUSE_OVERFLOW, 0);
        add_row("beq not taken", OP_BEQ, 6'h00, 1'b0, 1'b0,
                5, 0, DST_RT, WB_ALU_OUT, 0, PC_SRC_ALU, 0, CAUSE_OVERFLOW, 0);
        add_row("bne taken", OP_BNE, 6'h00, 1'b0, 1'b0,
                5, 0, DST_RT, WB_ALU_OUT, 1, PC_SRC_ALU_OUT, 0, CAUSE_OVERFLOW, 0);
        add_row("bne not taken", OP_BNE, 6'h00, 1'b0, 1'b1,
                5, 0, DST_RT, WB_ALU_OUT, 0, PC_SRC_ALU, 0, CAUSE_OVERFLOW, 0);
        add_row("j", OP_J, 6'h00, 1'b0, 1'b0,
                4, 0, DST_RT, WB_ALU_OUT, 1, PC_SRC_JUMP, 0, CAUSE_OVERFLOW, 0);
        add_row("jr", OP_RTYPE, FN_JR, 1'b0, 1'b0,
                4, 0, DST_RT, WB_ALU_OUT, 1, PC_SRC_REG_A, 0, CAUSE_OVERFLOW, 0);
        add_row("jal", OP_JAL, 6'h00, 1'b0, 1'b0,
                5, 1, DST_RA, WB_PC, 1, PC_SRC_JUMP, 0, CAUSE_OVERFLOW, 0);
        add_row("illegal opcode", 6'b111111, 6'h00, 1'b0, 1'b0,
                4, 0, DST_RT, WB_ALU_OUT, 1, PC_SRC_EXC, 1, CAUSE_ILLEGAL, 0);
        // mult function code, dropped from the instruction set
        add_row("illegal funct", OP_RTYPE, 6'b011000, 1'b0, 1'b0,
                4, 0, DST_RT, WB_ALU_OUT, 1, PC_SRC_EXC, 1, CAUSE_ILLEGAL, 0);
        add_row("add overflow", OP_RTYPE, FN_ADD, 1'b1, 1'b0,
                6, 0, DST_RT, WB_ALU_OUT, 1, PC_SRC_EXC, 1, CAUSE_OVERFLOW, 0);
        add_row("sub overflow", OP_RTYPE, FN_SUB, 1'b1, 1'b0,
                6, 0, DST_RT, WB_ALU_OUT, 1, PC_SRC_EXC, 1, CAUSE_OVERFLOW, 0);
        add_row("addi overflow", OP_ADDI, 6'h00, 1'b1, 1'b0,
                6, 0, DST_RT, WB_ALU_OUT, 1, PC_SRC_EXC, 1, CAUSE_OVERFLOW, 0);
        add_row("and overflow", OP_RTYPE, FN_AND, 1'b1, 1'b0,
                5, 1, DST_RD, WB_ALU_OUT, 0, PC_SRC_ALU, 0, CAUSE_OVERFLOW, 0);
    endtask

    task automatic apply_row(input entry_t row);
        opcode = row.opcode;
        funct = row.funct;
        overflow = row.overflow;
        zero = row.zero;
    endtask

    task automatic wait_for_ir_wr();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ctrl.ir_wr && cycles < 20);
        assert (ctrl.ir_wr)
        else fail_run("Timed out waiting for the next ir_wr pulse");
    endtask

    task automatic wait_for_window(input int count);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (done_q.size() < count && cycles < 20);
        assert (done_q.size() >= count)
        else fail_run("Timed out waiting for an instruction to end with a new ir_wr pulse");
    endtask

    task automatic check_window(input int idx);
        entry_t row;
        counts_t got;
        string name;
        row = table_q[idx];
        got = done_q[idx];
        name = name_q[idx];
        check_value(name, "length", int'(row.exp.length), int'(got.length));
        check_value(name, "reg_wr count", int'(row.exp.reg_wr_n), int'(got.reg_wr_n));
        if (row.exp.reg_wr_n != 4'd0) begin
            check_value(name, "reg_dst", int'(row.exp.reg_dst), int'(got.reg_dst));
            check_value(name, "wb_sel", int'(row.exp.wb_sel), int'(got.wb_sel));
        end
        check_value(name, "taken pc_wr count", int'(row.exp.jump_n), int'(got.jump_n));
        if (row.exp.jump_n != 4'd0) begin
            check_value(name, "pc_src", int'(row.exp.pc_src), int'(got.pc_src));
        end
        check_value(name, "epc_wr count", int'(row.exp.epc_n), int'(got.epc_n));
        if (row.exp.epc_n != 4'd0) begin
            check_value(name, "cause", int'(row.exp.cause), int'(got.cause));
        end
        check_value(name, "mem_wr count", int'(row.exp.mem_wr_n), int'(got.mem_wr_n));
    endtask

    initial begin
        reset = 1'b1;
        opcode = OP_RTYPE;
        funct = FN_ADD;
        overflow = 1'b0;
        zero = 1'b0;
        build_table();

        repeat (16) begin
            @(posedge clk);
            check_value("reset", "enables", 0, int'(enables(ctrl)));
        end
        @(negedge clk);
        reset = 1'b0;
        // Start cycle, then fetch step 0, then the ir_wr step
        @(posedge clk);
        check_value("start cycle", "enables", 0, int'(enables(ctrl)));
        @(posedge clk);
        check_value("first fetch", "ir_wr in cycle 2", 0, int'(ctrl.ir_wr));
        @(negedge clk);
        check_value("first fetch", "ir_wr in cycle 3", 1, int'(ctrl.ir_wr));

        // The external IR follows the DUT's ir_wr strobe
        for (int i = 0; i < table_q.size(); i++) begin
            if (i > 0) begin
                wait_for_ir_wr();
            end
            apply_row(table_q[i]);
            if (i > 0) begin
                wait_for_window(i);
                check_window(i - 1);
            end
        end
        wait_for_window(table_q.size());
        check_window(table_q.size() - 1);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
